/* source/uart_pkg.sv */
package uart_pkg;

    localparam int BYTE_W        = 8;   // Serial data byte width
    localparam int RX_DATA_BITS  = 8;   // Data bits per received frame
    localparam int TX_FRAME_BITS = 10;  // Start + 8 data + stop
    localparam int CMD_BYTES     = 3;   // Opcode, address, data

    typedef logic [BYTE_W-1:0] byte_t;  // One data byte

    // Command opcodes, first byte of a frame
    localparam byte_t OP_WRITE = 8'h01;
    localparam byte_t OP_READ  = 8'h02;
    localparam byte_t OP_ADD   = 8'h03;

    // Status byte, first byte of every reply
    localparam byte_t ST_WRITE_OK = 8'hA1;
    localparam byte_t ST_READ_OK  = 8'hA2;
    localparam byte_t ST_ADD_OK   = 8'hA3;
    localparam byte_t ST_ERROR    = 8'hEE;

    typedef enum logic [1:0] {
        CMD_WRITE   = 2'b00,        // Store data
        CMD_READ    = 2'b01,        // Return register
        CMD_ADD     = 2'b10,        // Register plus data, wraps
        CMD_INVALID = 2'b11         // Bad opcode or address
    } cmd_kind_t;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,           // Line idle, waiting for start edge
        RX_START = 2'b01,           // Start bit, re-checked at mid-bit
        RX_DATA  = 2'b10,           // Eight data bits, LSB first
        RX_STOP  = 2'b11            // Stop bit sample
    } rx_state_t;

endpackage

/* source/cmd_if.sv */
`timescale 1ns/1ps

interface cmd_if;
    import uart_pkg::*;

    logic      cmd_valid;   // One-cycle command strobe
    cmd_kind_t kind;        // Decoded command kind
    byte_t     addr;        // Register address, valid with strobe
    byte_t     data;        // Operand byte, valid with strobe

    // Decoder side
    modport source (
        output cmd_valid,
        output kind,
        output addr,
        output data
    );

    // Executor side
    modport sink (
        input cmd_valid,
        input kind,
        input addr,
        input data
    );

endinterface

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 50_000_000 / 115_200  // 115200 baud at 50 MHz
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            uart_in,        // Serial line, idles high
    output uart_pkg::byte_t rx_data,        // Last assembled byte
    output logic            rx_valid,       // Good stop bit, one cycle
    output logic            rx_frame_err    // Low stop bit, one cycle
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(RX_DATA_BITS);

    logic [1:0]       sync_q;     // Two-flop line synchronizer
    logic             rx_line;    // Synchronized line
    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;    // Position inside bit period
    logic [IDX_W-1:0] bit_idx;    // Data bit number
    logic             stop_q;     // Stop-bit sample
    logic             bit_mid;
    logic             bit_end;

    assign rx_line = sync_q[1];
    assign bit_mid = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2));  // Sample point
    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));  // Last count of bit

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= 2'b11;                        // Line assumed idle
        end else begin
            sync_q <= {sync_q[0], uart_in};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RX_IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid     <= 1'b0;                   // Pulses by default
            rx_frame_err <= 1'b0;
            // Detect cycle counts as count 0, so frames do not drift
            if (state == RX_IDLE)
                clk_cnt <= CNT_W'(1);
            else if (bit_end)
                clk_cnt <= '0;
            else
                clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    bit_idx <= '0;
                    if (!rx_line)
                        state <= RX_START;          // Falling edge seen
                end
                RX_START: begin
                    if (bit_mid && rx_line)
                        state <= RX_IDLE;           // Glitch, not a start bit
                    else if (bit_end)
                        state <= RX_DATA;
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;  // Wraps to 0 after bit 7
                        if (bit_idx == IDX_W'(RX_DATA_BITS - 1))
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        rx_valid     <= stop_q;     // Decided by mid-bit sample
                        rx_frame_err <= !stop_q;
                        state        <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_mid)
            rx_data <= {rx_line, rx_data[BYTE_W-1:1]};  // LSB first
        if (state == RX_STOP && bit_mid)
            stop_q <= rx_line;
    end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 50_000_000 / 115_200  // 115200 baud at 50 MHz
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            tx_start,   // Load and send one byte
    input  uart_pkg::byte_t tx_data,    // Byte to send
    output logic            tx_busy,    // High while frame on the line
    output logic            uart_out    // Serial line, idles high
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(TX_FRAME_BITS);

    logic [TX_FRAME_BITS-1:0] frame_q;  // Bit 0 is on the line
    logic [CNT_W-1:0]         clk_cnt;  // Position inside bit period
    logic [BIT_W-1:0]         bit_cnt;  // Frame bit being sent

    // Ones shift in behind the frame, so the line is high when done
    assign uart_out = frame_q[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_q <= '1;                          // Idle line
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame_q <= {1'b1, tx_data, 1'b0};   // Stop, data, start
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            frame_q <= {1'b1, frame_q[TX_FRAME_BITS-1:1]};  // Next bit
            if (bit_cnt == BIT_W'(TX_FRAME_BITS - 1))
                tx_busy <= 1'b0;                    // Stop bit finished
            else
                bit_cnt <= bit_cnt + 1'b1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

/* source/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode #(
    parameter int REG_COUNT = 8                 // Registers in the bank
) (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t rx_data,            // Received byte
    input  logic            rx_valid,           // Byte strobe
    input  logic            rx_frame_err,       // Bad stop bit strobe
    cmd_if.source           cmd                 // Decoded command out
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CMD_BYTES);

    logic [CNT_W-1:0] byte_cnt;     // Position in the frame
    byte_t            op_q;         // Latched opcode
    byte_t            addr_q;       // Latched address
    logic             addr_ok;
    logic             last_byte;
    cmd_kind_t        kind_next;

    assign addr_ok   = (addr_q < REG_COUNT);
    assign last_byte = (byte_cnt == CNT_W'(CMD_BYTES - 1));

    // Opcode lookup, any failure makes the command invalid
    always_comb begin
        kind_next = CMD_INVALID;
        if (addr_ok) begin
            case (op_q)
                OP_WRITE: kind_next = CMD_WRITE;
                OP_READ:  kind_next = CMD_READ;
                OP_ADD:   kind_next = CMD_ADD;
                default:  kind_next = CMD_INVALID;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt      <= '0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            cmd.cmd_valid <= 1'b0;
            if (rx_frame_err) begin
                byte_cnt <= '0;                     // Drop partial frame
            end else if (rx_valid) begin
                if (last_byte) begin
                    byte_cnt      <= '0;
                    cmd.cmd_valid <= 1'b1;          // Frame complete
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (rx_valid && !rx_frame_err) begin
            if (byte_cnt == '0)
                op_q <= rx_data;
            else if (!last_byte)
                addr_q <= rx_data;
            else begin
                cmd.kind <= kind_next;
                cmd.addr <= addr_q;
                cmd.data <= rx_data;                // Third byte goes straight out
            end
        end
    end

endmodule

/* source/reg_execute.sv */
`timescale 1ns/1ps

module reg_execute #(
    parameter int REG_COUNT = 8                 // Registers in the bank
) (
    input  logic            clk,
    input  logic            rst,
    cmd_if.sink             cmd,                // Decoded command in
    output logic            res_valid,          // Result strobe
    output uart_pkg::byte_t res_status,         // Reply status byte
    output uart_pkg::byte_t res_value           // Reply value byte
);
    import uart_pkg::*;

    localparam int AW = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

    byte_t         regs [REG_COUNT];    // Register bank
    logic [AW-1:0] idx;                 // Register index
    byte_t         cur;                 // Addressed register
    byte_t         sum;                 // Add result, mod 256

    assign idx = cmd.addr[AW-1:0];      // Range already checked upstream
    assign cur = regs[idx];
    assign sum = cur + cmd.data;        // 8-bit wraparound

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= cmd.cmd_valid;             // One cycle behind command
            if (cmd.cmd_valid) begin
                case (cmd.kind)
                    CMD_WRITE: regs[idx] <= cmd.data;
                    CMD_ADD:   regs[idx] <= sum;
                    default:   ;                    // Read or invalid, no change
                endcase
            end
        end
    end

    // Reply bytes
    always_ff @(posedge clk) begin
        if (cmd.cmd_valid) begin
            case (cmd.kind)
                CMD_WRITE: begin
                    res_status <= ST_WRITE_OK;
                    res_value  <= cmd.data;         // Echo written data
                end
                CMD_READ: begin
                    res_status <= ST_READ_OK;
                    res_value  <= cur;
                end
                CMD_ADD: begin
                    res_status <= ST_ADD_OK;
                    res_value  <= sum;
                end
                default: begin
                    res_status <= ST_ERROR;
                    res_value  <= '0;
                end
            endcase
        end
    end

endmodule

/* source/resp_format.sv */
`timescale 1ns/1ps

module resp_format (
    input  logic            clk,
    input  logic            rst,
    input  logic            res_valid,      // Result strobe
    input  uart_pkg::byte_t res_status,     // First reply byte
    input  uart_pkg::byte_t res_value,      // Second reply byte
    input  logic            tx_busy,        // Transmitter level
    output logic            tx_start,       // Send strobe
    output uart_pkg::byte_t tx_data         // Byte for the transmitter
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        FMT_IDLE   = 2'b00,     // Waiting for a result
        FMT_STATUS = 2'b01,     // Status byte on the line
        FMT_VALUE  = 2'b10      // Value byte on the line
    } fmt_state_t;

    fmt_state_t state;
    logic       busy_q;         // Delayed busy for edge detect
    logic       busy_fall;      // Transmitter just finished
    byte_t      value_q;        // Held value byte

    assign busy_fall = busy_q && !tx_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FMT_IDLE;
            busy_q   <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            busy_q   <= tx_busy;
            tx_start <= 1'b0;
            case (state)
                FMT_IDLE: begin
                    if (res_valid) begin
                        tx_start <= 1'b1;           // Status byte out
                        state    <= FMT_STATUS;
                    end
                end
                FMT_STATUS: begin
                    if (busy_fall) begin
                        tx_start <= 1'b1;           // Value byte out
                        state    <= FMT_VALUE;
                    end
                end
                FMT_VALUE: if (busy_fall) state <= FMT_IDLE;
                default:   state <= FMT_IDLE;
            endcase
        end
    end

    // Byte selection
    always_ff @(posedge clk) begin
        if (state == FMT_IDLE && res_valid) begin
            tx_data <= res_status;
            value_q <= res_value;
        end else if (state == FMT_STATUS && busy_fall) begin
            tx_data <= value_q;
        end
    end

endmodule

/* source/uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top #(
    parameter int CLKS_PER_BIT = 50_000_000 / 115_200,  // 115200 baud at 50 MHz
    parameter int REG_COUNT    = 8                      // Register bank size
) (
    input  logic clk,
    input  logic rst,
    input  logic uart_in,       // Command line from host
    output logic uart_out       // Reply line to host
);
    import uart_pkg::*;

    byte_t rx_data;             // Receiver to decoder
    logic  rx_valid;
    logic  rx_frame_err;
    logic  res_valid;           // Executor to formatter
    byte_t res_status;
    byte_t res_value;
    logic  tx_start;            // Formatter to transmitter
    byte_t tx_data;
    logic  tx_busy;

    cmd_if cmd_bus ();          // Decoder to executor

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk          (clk),
        .rst          (rst),
        .uart_in      (uart_in),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    cmd_decode #(.REG_COUNT(REG_COUNT)) u_decode (
        .clk          (clk),
        .rst          (rst),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err),
        .cmd          (cmd_bus.source)
    );

    reg_execute #(.REG_COUNT(REG_COUNT)) u_execute (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_bus.sink),
        .res_valid  (res_valid),
        .res_status (res_status),
        .res_value  (res_value)
    );

    resp_format u_format (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res_status (res_status),
        .res_value  (res_value),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_data    (tx_data)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .uart_out (uart_out)
    );

endmodule

/* verif/uart_cmd_props.sv */
`timescale 1ns/1ps

module uart_cmd_props (
    input logic                clk,
    input logic                rst,
    input logic                rx_valid,
    input logic                rx_frame_err,
    input logic                cmd_valid,
    input logic                tx_start,
    input logic                tx_busy,
    input logic                uart_out
);

    int assert_errors = 0;          // Failed assertion count

    a_rx_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(rx_valid && rx_frame_err))
        else begin
            $error("Receiver raised a valid byte and a framing error together");
            assert_errors++;
        end

    a_tx_start_idle: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy)
        else begin
            $error("Transmitter started while busy");
            assert_errors++;
        end

    a_line_idle: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> uart_out)
        else begin
            $error("Serial output low while transmitter idle");
            assert_errors++;
        end

    a_cmd_after_rx: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> $past(rx_valid))
        else begin
            $error("Command strobe without a received byte one cycle before");
            assert_errors++;
        end

endmodule

bind uart_cmd_top uart_cmd_props u_props (
    .clk          (clk),
    .rst          (rst),
    .rx_valid     (rx_valid),
    .rx_frame_err (rx_frame_err),
    .cmd_valid    (cmd_bus.cmd_valid),
    .tx_start     (tx_start),
    .tx_busy      (tx_busy),
    .uart_out     (uart_out)
);

/* verif/tb_uart_cmd.sv */
`timescale 1ns/1ps

module tb_uart_cmd;
    import uart_pkg::*;

    localparam int CLKS_PER_BIT = 16;                   // Fast serial rate for simulation
    localparam int REG_COUNT    = 8;
    localparam int CLK_PERIOD   = 100;                  // ns
    localparam int MAX_CASES    = 64;
    localparam int GAP_BITS     = 4;                    // Idle bits before a spaced command
    localparam int REPLY_WAIT   = 100 * CLKS_PER_BIT;   // Cycles allowed until a start bit
    localparam int F_MODE       = 0;                    // Case table columns
    localparam int F_OP         = 1;
    localparam int F_ADDR       = 2;
    localparam int F_DATA       = 3;
    localparam int F_STATUS     = 4;
    localparam int F_VALUE      = 5;

    logic       clk;
    logic       rst;
    logic       uart_in;                        // Host to DUT
    logic       uart_out;                       // DUT to host
    logic [7:0] case_tab [MAX_CASES][6];        // One row per command
    int         n_cases;
    logic       cases_loaded;                   // Starts the watchdog

    uart_cmd_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .REG_COUNT    (REG_COUNT)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .uart_in  (uart_in),
        .uart_out (uart_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic compare_byte(input logic [7:0] actual, input logic [7:0] expected,
                                input string what);
        if (actual !== expected)
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                $time, what, actual, expected));
    endtask

    // Rows of six hex fields, anything else on a line is skipped
    task automatic load_cases();
        int    fd;
        int    got;
        string line;
        fd = $fopen("verif/uart_cmd_cases.txt", "r");
        if (fd == 0)
            abort_run("Could not open the case file verif/uart_cmd_cases.txt");
        n_cases = 0;
        got     = 0;
        while (got != -1 && n_cases < MAX_CASES) begin
            got = $fscanf(fd, "%h %h %h %h %h %h",
                          case_tab[n_cases][F_MODE], case_tab[n_cases][F_OP],
                          case_tab[n_cases][F_ADDR], case_tab[n_cases][F_DATA],
                          case_tab[n_cases][F_STATUS], case_tab[n_cases][F_VALUE]);
            if (got == 6)
                n_cases++;
            else if (got != -1 && $fgets(line, fd) == 0)
                got = -1;                       // Nothing left to read
        end
        $fclose(fd);
        if (n_cases == 0)
            abort_run("The case file holds no commands");
        cases_loaded = 1'b1;
    endtask

    // One frame, each bit held CLKS_PER_BIT cycles
    task automatic send_byte(input byte_t value, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, value, 1'b0};        // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 uart_in = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic idle_bits(input int n);
        @(posedge clk);
        #1 uart_in = 1'b1;
        repeat (n * CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // Mode 0 spaced, 1 partial frame and bad stop bit first, 2 no gap
    task automatic send_command(input int idx);
        if (case_tab[idx][F_MODE] == 8'h01) begin
            send_byte(case_tab[idx][F_OP], 1'b1);  // Opcode only, frame left open
            send_byte(8'h5A, 1'b0);                 // Low stop bit
            idle_bits(2);
        end else if (case_tab[idx][F_MODE] == 8'h00) begin
            idle_bits(GAP_BITS);
        end
        send_byte(case_tab[idx][F_OP], 1'b1);
        send_byte(case_tab[idx][F_ADDR], 1'b1);
        send_byte(case_tab[idx][F_DATA], 1'b1);
    endtask

    // Samples on the falling clock, away from line updates
    task automatic receive_byte(input int idx, output byte_t value);
        int waited;
        waited = 0;
        while (uart_out === 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > REPLY_WAIT)
                abort_run($sformatf("No reply from the DUT for case %0d", idx));
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of start bit
        compare_byte({7'b0, uart_out}, 8'h00, $sformatf("case %0d start bit", idx));
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            value[i] = uart_out;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        compare_byte({7'b0, uart_out}, 8'h01, $sformatf("case %0d stop bit", idx));
    endtask

    initial begin
        rst          = 1'b1;
        uart_in      = 1'b1;                    // Idle line
        cases_loaded = 1'b0;
        n_cases      = 0;
        load_cases();
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        fork
            begin
                for (int i = 0; i < n_cases; i++)
                    send_command(i);
            end
            begin : monitor
                byte_t status;
                byte_t value;
                for (int j = 0; j < n_cases; j++) begin
                    receive_byte(j, status);
                    receive_byte(j, value);
                    compare_byte(status, case_tab[j][F_STATUS],
                                 $sformatf("case %0d status", j));
                    compare_byte(value, case_tab[j][F_VALUE],
                                 $sformatf("case %0d value", j));
                end
            end
        join
        $display("All tests passed!");
        $finish;
    end

    // Bound protocol checks count their failures
    initial begin
        wait (uut.u_props.assert_errors != 0);
        abort_run("A protocol assertion in the bound checker failed");
    end

    // 60 bit periods per case, doubled, plus reset
    initial begin
        wait (cases_loaded);
        #(2 * n_cases * 60 * CLKS_PER_BIT * CLK_PERIOD + 10 * CLK_PERIOD);
        abort_run("Watchdog expired before all replies were checked");
    end

endmodule

/* verif/uart_cmd_cases.txt */
# mode opcode addr data status value, all hex
# mode 0 idle gap first, 1 partial frame and bad stop bit first, 2 no gap
00 02 00 00 A2 00
02 02 01 00 A2 00
02 02 02 00 A2 00
02 02 03 00 A2 00
02 02 04 00 A2 00
02 02 05 00 A2 00
02 02 06 00 A2 00
02 02 07 00 A2 00
00 01 02 5A A1 5A
00 02 02 00 A2 5A
00 03 04 35 A3 35
00 03 04 F0 A3 25
00 02 04 00 A2 25
00 07 02 11 EE 00
00 02 02 00 A2 5A
00 01 08 77 EE 00
00 02 00 00 A2 00
01 01 05 9C A1 9C
01 02 05 00 A2 9C
02 03 02 06 A3 60
02 02 02 00 A2 60
02 01 06 81 A1 81
02 02 06 00 A2 81

/* compile.f */
source/uart_pkg.sv
source/cmd_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_decode.sv
source/reg_execute.sv
source/resp_format.sv
source/uart_cmd_top.sv
verif/uart_cmd_props.sv
verif/tb_uart_cmd.sv

/* Bender.yml */
package:
  name: uart_cmd

sources:
  - source/uart_pkg.sv
  - source/cmd_if.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/cmd_decode.sv
  - source/reg_execute.sv
  - source/resp_format.sv
  - source/uart_cmd_top.sv
  - target: test
    files:
      - verif/uart_cmd_props.sv
      - verif/tb_uart_cmd.sv
